// File: hdl/axiSramPkg.sv
package axiSramPkg;

    // Bus widths
    localparam int addrBits     = 32;
    localparam int dataBits     = 32;
    localparam int strbBits     = 4;
    localparam int idBits       = 8;
    localparam int lenBits      = 4;
    localparam int sizeBits     = 3;

    // SRAM geometry
    localparam int sramAddrBits = 14;
    localparam int sramDepth    = 16384;

    // Largest legal AxSIZE, 4 bytes
    localparam logic [sizeBits-1:0] maxSize = 3'd2;

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlverr = 2'b10;
    localparam logic [1:0] respDecerr = 2'b11;

    localparam logic [1:0] burstFixed = 2'b00;
    localparam logic [1:0] burstIncr  = 2'b01;

    // Accepted WSTRB patterns, data always low-justified
    localparam logic [strbBits-1:0] strbWord = 4'b1111;
    localparam logic [strbBits-1:0] strbHalf = 4'b0011;
    localparam logic [strbBits-1:0] strbByte = 4'b0001;

    localparam logic [15:0] regionRom = 16'd0; // Read only
    localparam logic [15:0] regionRam = 16'd1;

    // Byte address, either as a number or split for decode
    typedef union packed {
        logic [addrBits-1:0] raw;
        struct packed {
            logic [15:0]             region;
            logic [sramAddrBits-1:0] wordIndex;
            logic [1:0]              byteOffset;
        } f;
    } axiAddrT;

endpackage

// File: hdl/axiSramTop.sv
`timescale 1ns/1ps

module axiSramTop import axiSramPkg::*; (
    input  logic                ACLK,
    input  logic                ARESETn,
    // Write address
    input  logic [idBits-1:0]   AWID,
    input  logic [addrBits-1:0] AWADDR,
    input  logic [lenBits-1:0]  AWLEN,
    input  logic [sizeBits-1:0] AWSIZE,
    input  logic [1:0]          AWBURST,
    input  logic                AWVALID,
    output logic                AWREADY,
    // Write data
    input  logic [dataBits-1:0] WDATA,
    input  logic [strbBits-1:0] WSTRB,
    input  logic                WLAST,
    input  logic                WVALID,
    output logic                WREADY,
    // Write response
    output logic [idBits-1:0]   BID,
    output logic [1:0]          BRESP,
    output logic                BVALID,
    input  logic                BREADY,
    // Read address
    input  logic [idBits-1:0]   ARID,
    input  logic [addrBits-1:0] ARADDR,
    input  logic [lenBits-1:0]  ARLEN,
    input  logic [sizeBits-1:0] ARSIZE,
    input  logic [1:0]          ARBURST,
    input  logic                ARVALID,
    output logic                ARREADY,
    // Read data
    output logic [idBits-1:0]   RID,
    output logic [dataBits-1:0] RDATA,
    output logic [1:0]          RRESP,
    output logic                RLAST,
    output logic                RVALID,
    input  logic                RREADY
);

    logic                    wrReq, wrGrant, rdReq, rdGrant;
    logic [sramAddrBits-1:0] wrAddr, rdAddr, addr;
    logic [dataBits-1:0]     wrData, dataIn, dataOut;
    logic [strbBits-1:0]     wrByteEn, web;
    logic                    cs;

    writeEngine writeEngine_i (
        .ACLK, .ARESETn,
        .AWID, .AWADDR, .AWLEN, .AWSIZE, .AWBURST, .AWVALID, .AWREADY,
        .WDATA, .WSTRB, .WLAST, .WVALID, .WREADY,
        .BID, .BRESP, .BVALID, .BREADY,
        .wrReq, .wrGrant, .wrAddr, .wrData, .wrByteEn
    );

    readEngine readEngine_i (
        .ACLK, .ARESETn,
        .ARID, .ARADDR, .ARLEN, .ARSIZE, .ARBURST, .ARVALID, .ARREADY,
        .RID, .RDATA, .RRESP, .RLAST, .RVALID, .RREADY,
        .rdReq, .rdGrant, .rdAddr,
        .rdData (dataOut)
    );

    sramArbiter sramArbiter_i (
        .wrReq, .wrAddr, .wrData, .wrByteEn,
        .rdReq, .rdAddr,
        .wrGrant, .rdGrant,
        .cs, .web, .addr, .dataIn
    );

    sramModel sramModel_i (
        .ACLK,
        .cs,
        .web,
        .addr,
        .dataIn,
        .dataOut
    );

endmodule

// File: hdl/readEngine.sv
`timescale 1ns/1ps

module readEngine import axiSramPkg::*; (
    input  logic                    ACLK,
    input  logic                    ARESETn,
    input  logic [idBits-1:0]       ARID,
    input  logic [addrBits-1:0]     ARADDR,
    input  logic [lenBits-1:0]      ARLEN,
    input  logic [sizeBits-1:0]     ARSIZE,
    input  logic [1:0]              ARBURST,
    input  logic                    ARVALID,
    output logic                    ARREADY,
    output logic [idBits-1:0]       RID,
    output logic [dataBits-1:0]     RDATA,
    output logic [1:0]              RRESP,
    output logic                    RLAST,
    output logic                    RVALID,
    input  logic                    RREADY,
    output logic                    rdReq,
    input  logic                    rdGrant,
    output logic [sramAddrBits-1:0] rdAddr,
    input  logic [dataBits-1:0]     rdData
);

    axiAddrT             reqAddr;
    axiAddrT             arAddr;
    logic [sizeBits-1:0] arSize;
    logic [1:0]          arBurst;
    logic [lenBits-1:0]  rCount; // Beats left after the current one
    logic [1:0]          arResp;
    logic                arFire, rFire;
    logic                nextBeat, beatOk;
    logic                fetched;
    logic                errWait;

    assign arFire = ARVALID & ARREADY;
    assign rFire  = RVALID & RREADY;

    assign reqAddr.raw = ARADDR;
    assign rdAddr      = arAddr.f.wordIndex;

    always_comb begin
        if (reqAddr.f.region == regionRom || reqAddr.f.region == regionRam) begin
            if (ARSIZE > maxSize || (ARBURST != burstFixed && ARBURST != burstIncr)) begin
                arResp = respSlverr;
            end else begin
                arResp = respOkay;
            end
        end else begin
            arResp = respDecerr;
        end
    end

    // A new beat starts after AR or after a non-final R handshake
    assign nextBeat = arFire | (rFire & ~RLAST);
    assign beatOk   = arFire ? (arResp == respOkay) : (RRESP == respOkay);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            ARREADY <= 1'b1;
            rdReq   <= 1'b0;
            fetched <= 1'b0;
            errWait <= 1'b0;
            RVALID  <= 1'b0;
            RLAST   <= 1'b0;
        end else begin
            if (arFire) begin
                ARREADY <= 1'b0;
            end else if (rFire && RLAST) begin
                ARREADY <= 1'b1;
            end

            if (nextBeat && beatOk) begin
                rdReq <= 1'b1;
            end else if (rdGrant) begin
                rdReq <= 1'b0;
            end

            fetched <= rdReq & rdGrant; // SRAM word lands on dataOut next cycle
            errWait <= nextBeat & ~beatOk;

            if (fetched || errWait) begin
                RVALID <= 1'b1;
                RLAST  <= (rCount == '0);
            end else if (rFire) begin
                RVALID <= 1'b0;
                RLAST  <= 1'b0;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (arFire) begin
            arAddr  <= reqAddr;
            arSize  <= ARSIZE;
            arBurst <= ARBURST;
            rCount  <= ARLEN;
            RID     <= ARID;
            RRESP   <= arResp;
        end
        if (rFire) begin
            rCount <= rCount - 1'b1;
            if (arBurst == burstIncr) begin
                arAddr.raw <= arAddr.raw + (addrBits'(1) << arSize);
            end
        end
        if (fetched) begin
            RDATA <= rdData;
        end else if (errWait) begin
            RDATA <= '0;
        end
    end

endmodule

// File: hdl/sramArbiter.sv
`timescale 1ns/1ps

module sramArbiter import axiSramPkg::*; (
    input  logic                    wrReq,
    input  logic [sramAddrBits-1:0] wrAddr,
    input  logic [dataBits-1:0]     wrData,
    input  logic [strbBits-1:0]     wrByteEn,
    input  logic                    rdReq,
    input  logic [sramAddrBits-1:0] rdAddr,
    output logic                    wrGrant,
    output logic                    rdGrant,
    output logic                    cs,
    output logic [strbBits-1:0]     web,
    output logic [sramAddrBits-1:0] addr,
    output logic [dataBits-1:0]     dataIn
);

    // Write always wins a same-cycle conflict
    assign wrGrant = wrReq;
    assign rdGrant = rdReq & ~wrReq;

    assign cs = wrGrant | rdGrant;

    always_comb begin
        if (wrGrant) begin
            web    = wrByteEn;
            addr   = wrAddr;
            dataIn = wrData;
        end else begin
            web    = '1; // Read, no byte lanes written
            addr   = rdAddr;
            dataIn = '0;
        end
    end

endmodule

// File: hdl/sramModel.sv
`timescale 1ns/1ps

module sramModel import axiSramPkg::*; (
    input  logic                    ACLK,
    input  logic                    cs,
    input  logic [strbBits-1:0]     web,
    input  logic [sramAddrBits-1:0] addr,
    input  logic [dataBits-1:0]     dataIn,
    output logic [dataBits-1:0]     dataOut
);

    logic [dataBits-1:0] mem [sramDepth];

    always_ff @(posedge ACLK) begin
        if (cs) begin
            for (int i = 0; i < strbBits; i++) begin
                if (!web[i]) begin
                    mem[addr][8*i +: 8] <= dataIn[8*i +: 8];
                end
            end
            dataOut <= mem[addr]; // Old word on a write edge
        end
    end

endmodule

// File: hdl/writeEngine.sv
`timescale 1ns/1ps

module writeEngine import axiSramPkg::*; (
    input  logic                    ACLK,
    input  logic                    ARESETn,
    input  logic [idBits-1:0]       AWID,
    input  logic [addrBits-1:0]     AWADDR,
    input  logic [lenBits-1:0]      AWLEN,
    input  logic [sizeBits-1:0]     AWSIZE,
    input  logic [1:0]              AWBURST,
    input  logic                    AWVALID,
    output logic                    AWREADY,
    input  logic [dataBits-1:0]     WDATA,
    input  logic [strbBits-1:0]     WSTRB,
    input  logic                    WLAST,
    input  logic                    WVALID,
    output logic                    WREADY,
    output logic [idBits-1:0]       BID,
    output logic [1:0]              BRESP,
    output logic                    BVALID,
    input  logic                    BREADY,
    output logic                    wrReq,
    input  logic                    wrGrant,
    output logic [sramAddrBits-1:0] wrAddr,
    output logic [dataBits-1:0]     wrData,
    output logic [strbBits-1:0]     wrByteEn
);

    axiAddrT             reqAddr;
    axiAddrT             awAddr;
    logic [sizeBits-1:0] awSize;
    logic [1:0]          awBurst;
    logic [lenBits-1:0]  wCount;
    logic                lastBeat;
    logic [1:0]          awResp;
    logic                awFire, wFire, bFire;
    logic                beatLast, beatWrites;
    logic [dataBits-1:0] laneData;
    logic [strbBits-1:0] laneEn;
    logic                laneOk;

    assign awFire = AWVALID & AWREADY;
    assign wFire  = WVALID & WREADY;
    assign bFire  = BVALID & BREADY;

    assign reqAddr.raw = AWADDR;

    // Region decides first, then size and burst type
    always_comb begin
        if (reqAddr.f.region == regionRom) begin
            awResp = respSlverr;
        end else if (reqAddr.f.region != regionRam) begin
            awResp = respDecerr;
        end else if (AWSIZE > maxSize || (AWBURST != burstFixed && AWBURST != burstIncr)) begin
            awResp = respSlverr;
        end else begin
            awResp = respOkay;
        end
    end

    // Strobe decode, enables active low
    always_comb begin
        laneData = WDATA;
        laneEn   = '1;
        laneOk   = 1'b1;
        case (WSTRB)
            strbWord: laneEn = '0; // Offset ignored for full words
            strbHalf: begin
                if (!awAddr.f.byteOffset[0]) begin
                    laneData = dataBits'(WDATA[15:0]) << {awAddr.f.byteOffset, 3'b000};
                    laneEn   = ~(strbHalf << awAddr.f.byteOffset);
                end else begin
                    laneOk = 1'b0;
                end
            end
            strbByte: begin
                laneData = dataBits'(WDATA[7:0]) << {awAddr.f.byteOffset, 3'b000};
                laneEn   = ~(strbByte << awAddr.f.byteOffset);
            end
            default: laneOk = 1'b0;
        endcase
    end

    assign beatWrites = (BRESP == respOkay) && laneOk;
    assign beatLast   = WLAST || (wCount == '0);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            AWREADY <= 1'b1;
            WREADY  <= 1'b0;
            wrReq   <= 1'b0;
            BVALID  <= 1'b0;
        end else begin
            if (awFire) begin
                AWREADY <= 1'b0;
                WREADY  <= 1'b1;
            end
            if (wFire) begin
                if (beatWrites) begin
                    WREADY <= 1'b0;
                    wrReq  <= 1'b1; // Hold until the arbiter grants
                end else if (beatLast) begin
                    WREADY <= 1'b0;
                    BVALID <= 1'b1;
                end
            end
            if (wrReq && wrGrant) begin
                wrReq <= 1'b0;
                if (lastBeat) BVALID <= 1'b1;
                else          WREADY <= 1'b1;
            end
            if (bFire) begin
                BVALID  <= 1'b0;
                AWREADY <= 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (awFire) begin
            awAddr  <= reqAddr;
            awSize  <= AWSIZE;
            awBurst <= AWBURST;
            wCount  <= AWLEN;
            BID     <= AWID;
            BRESP   <= awResp;
        end
        if (wFire) begin
            wrAddr   <= awAddr.f.wordIndex;
            wrData   <= laneData;
            wrByteEn <= laneEn;
            lastBeat <= beatLast;
            wCount   <= wCount - 1'b1;
            if (awBurst == burstIncr) begin
                awAddr.raw <= awAddr.raw + (addrBits'(1) << awSize);
            end
        end
    end

endmodule

// File: sim/axiSramTb.sv
`timescale 1ns/1ps

module axiSramTb import axiSramPkg::*; ();

    localparam int totalBeats    = 60;
    localparam int timeoutCycles = totalBeats * 20 + 200;

    logic                ACLK, ARESETn;
    logic [idBits-1:0]   AWID, BID, ARID, RID;
    logic [addrBits-1:0] AWADDR, ARADDR;
    logic [lenBits-1:0]  AWLEN, ARLEN;
    logic [sizeBits-1:0] AWSIZE, ARSIZE;
    logic [1:0]          AWBURST, ARBURST, BRESP, RRESP;
    logic [dataBits-1:0] WDATA, RDATA;
    logic [strbBits-1:0] WSTRB;
    logic                AWVALID, AWREADY, WLAST, WVALID, WREADY, BVALID, BREADY;
    logic                ARVALID, ARREADY, RLAST, RVALID, RREADY;

    logic [dataBits-1:0] shadow [sramDepth]; // Expected SRAM contents
    integer seed = 32'h3fb1;
    int mismatches = 0;
    int extraBeats = 0;
    int cycles = 0;

    axiSramTop axiSramTop_i (.*);

    bind axiSramTop axiSramChecker axiSramChecker_i (
        .ACLK, .ARESETn, .RVALID, .RREADY, .RDATA, .RRESP, .RLAST,
        .BVALID, .BREADY, .wrReq, .rdReq, .wrGrant, .rdGrant, .cs
    );

    always #50 ACLK = ~ACLK;

    always @(posedge ACLK) begin
        cycles = cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic tick();
        @(posedge ACLK);
        #5;
    endtask

    task automatic checkData(input logic [dataBits-1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic checkResp(input logic [1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic checkId(input logic [idBits-1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic checkLast(input logic got, exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // Response from the start address, region before size
    function automatic logic [1:0] expectedResp(input axiAddrT a, input logic [sizeBits-1:0] size,
                                                input logic [1:0] burst, input logic isWrite);
        if (a.f.region != regionRom && a.f.region != regionRam) return respDecerr;
        if (isWrite && a.f.region == regionRom) return respSlverr;
        if (size > maxSize || burst > burstIncr) return respSlverr;
        return respOkay;
    endfunction

    task automatic applyWrite(input axiAddrT a, input logic [strbBits-1:0] strb,
                              input logic [dataBits-1:0] data);
        int lane;
        lane = a.f.byteOffset;
        case (strb)
            strbWord: shadow[a.f.wordIndex] = data;
            strbHalf: begin
                if (lane % 2 == 0) begin
                    shadow[a.f.wordIndex][8*lane +: 16] = data[15:0];
                end
            end
            strbByte: shadow[a.f.wordIndex][8*lane +: 8] = data[7:0];
            default: ; // Other patterns write nothing
        endcase
    endtask

    task automatic writeBurst(input logic [idBits-1:0] id, input logic [addrBits-1:0] addr,
                              input int beats, input logic [sizeBits-1:0] size,
                              input logic [1:0] burst, input logic [strbBits-1:0] strb);
        axiAddrT             a;
        logic [1:0]          resp;
        logic [dataBits-1:0] data;
        a.raw = addr;
        resp  = expectedResp(a, size, burst, 1'b1);
        AWID    = id;
        AWADDR  = addr;
        AWLEN   = lenBits'(beats - 1);
        AWSIZE  = size;
        AWBURST = burst;
        AWVALID = 1'b1;
        while (!AWREADY) begin
            tick();
        end
        tick();
        AWVALID = 1'b0;
        for (int i = 0; i < beats; i++) begin
            data   = $random(seed); // Upper lanes random on narrow beats
            WDATA  = data;
            WSTRB  = strb;
            WLAST  = (i == beats - 1);
            WVALID = 1'b1;
            while (!WREADY) begin
                tick();
            end
            if (resp == respOkay) begin
                applyWrite(a, strb, data);
            end
            if (burst == burstIncr) begin
                a.raw = a.raw + (addrBits'(1) << size);
            end
            tick();
        end
        WVALID = 1'b0;
        WLAST  = 1'b0;
        while (!BVALID) begin
            tick();
        end
        tick(); // Response held one cycle with BREADY low
        BREADY = 1'b1;
        checkResp(BRESP, resp, "BRESP");
        checkId(BID, id, "BID");
        tick();
        BREADY = 1'b0;
    endtask

    task automatic readBurst(input logic [idBits-1:0] id, input logic [addrBits-1:0] addr,
                             input int beats, input logic [sizeBits-1:0] size,
                             input logic [1:0] burst, input logic stall);
        axiAddrT             a;
        logic [1:0]          resp;
        logic [dataBits-1:0] expData;
        a.raw = addr;
        resp  = expectedResp(a, size, burst, 1'b0);
        ARID    = id;
        ARADDR  = addr;
        ARLEN   = lenBits'(beats - 1);
        ARSIZE  = size;
        ARBURST = burst;
        ARVALID = 1'b1;
        while (!ARREADY) begin
            tick();
        end
        tick();
        ARVALID = 1'b0;
        for (int i = 0; i < beats; i++) begin
            RREADY = !stall || ($random(seed) & 1);
            while (!(RVALID && RREADY)) begin
                tick();
                RREADY = !stall || ($random(seed) & 1);
            end
            expData = (resp == respOkay) ? shadow[a.f.wordIndex] : '0; // Error beats carry zero
            checkData(RDATA, expData, "RDATA");
            checkResp(RRESP, resp, "RRESP");
            checkId(RID, id, "RID");
            checkLast(RLAST, i == beats - 1, "RLAST");
            if (burst == burstIncr) begin
                a.raw = a.raw + (addrBits'(1) << size);
            end
            tick();
        end
        RREADY = 1'b0;
        repeat (2) tick(); // Any further beat shows within two cycles
        if (RVALID) begin
            $display("Read burst at %h returned more than %0d beats", addr, beats);
            extraBeats++;
        end
    endtask

    initial begin
        ACLK    = 1'b0;
        ARESETn = 1'b0;
        {AWVALID, WVALID, WLAST, BREADY, ARVALID, RREADY} = '0;
        {AWID, AWADDR, AWLEN, AWSIZE, AWBURST} = '0;
        {ARID, ARADDR, ARLEN, ARSIZE, ARBURST} = '0;
        {WDATA, WSTRB} = '0;
        repeat (16) @(posedge ACLK);
        #5;
        ARESETn = 1'b1;
        tick();

        writeBurst(8'h11, 32'h0001_0100, 8, 3'd2, burstIncr, strbWord);
        readBurst(8'h12, 32'h0001_0100, 8, 3'd2, burstIncr, 1'b0);

        // All byte lanes, both half lanes, one misaligned half
        for (int i = 0; i < 4; i++) begin
            writeBurst(8'h21, 32'h0001_0200 + i, 1, 3'd0, burstIncr, strbByte);
        end
        writeBurst(8'h22, 32'h0001_0204, 1, 3'd1, burstIncr, strbHalf);
        writeBurst(8'h22, 32'h0001_0206, 1, 3'd1, burstIncr, strbHalf);
        writeBurst(8'h23, 32'h0001_0205, 1, 3'd1, burstIncr, strbHalf);
        readBurst(8'h24, 32'h0001_0200, 2, 3'd2, burstIncr, 1'b0);
        readBurst(8'h25, 32'h0000_0200, 2, 3'd2, burstIncr, 1'b0); // Region 0 alias

        writeBurst(8'h31, 32'h0001_0300, 2, 3'd2, burstIncr, strbWord);
        writeBurst(8'h32, 32'h0000_0300, 2, 3'd2, burstIncr, strbWord);
        readBurst(8'h33, 32'h0001_0300, 2, 3'd2, burstIncr, 1'b0);

        writeBurst(8'h41, 32'h0002_0000, 2, 3'd2, burstIncr, strbWord);
        readBurst(8'h42, 32'h0002_0000, 3, 3'd2, burstIncr, 1'b0);
        readBurst(8'h43, 32'h0001_0100, 4, 3'd3, burstIncr, 1'b0);
        writeBurst(8'h44, 32'h0001_0100, 1, 3'd3, burstIncr, strbWord);

        writeBurst(8'h51, 32'h0001_0400, 4, 3'd2, burstFixed, strbWord);
        readBurst(8'h52, 32'h0001_0400, 1, 3'd2, burstFixed, 1'b0);
        // Both engines busy at once, disjoint words
        fork
            writeBurst(8'h53, 32'h0001_0500, 4, 3'd2, burstIncr, strbWord);
            readBurst(8'h54, 32'h0001_0100, 8, 3'd2, burstIncr, 1'b1);
        join

        tick();
        $display("Errors: %0d mismatches, %0d extra beats, %0d assertion failures",
                 mismatches, extraBeats, axiSramTop_i.axiSramChecker_i.failures);
        if (mismatches == 0 && extraBeats == 0 && axiSramTop_i.axiSramChecker_i.failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sim/axiSram_assertions.sv
`timescale 1ns/1ps

module axiSramChecker import axiSramPkg::*; (
    input logic                ACLK,
    input logic                ARESETn,
    input logic                RVALID,
    input logic                RREADY,
    input logic [dataBits-1:0] RDATA,
    input logic [1:0]          RRESP,
    input logic                RLAST,
    input logic                BVALID,
    input logic                BREADY,
    input logic                wrReq,
    input logic                rdReq,
    input logic                wrGrant,
    input logic                rdGrant,
    input logic                cs
);

    int failures = 0; // Failed assertion count

    // R beat held under back-pressure
    rHeld: assert property (@(posedge ACLK) disable iff (!ARESETn)
        RVALID && !RREADY |=> RVALID && $stable(RDATA) && $stable(RRESP) && $stable(RLAST))
        else begin
            $error("R channel changed while RREADY was low");
            failures++;
        end

    bHeld: assert property (@(posedge ACLK) disable iff (!ARESETn)
        BVALID && !BREADY |=> BVALID)
        else begin
            $error("BVALID dropped before BREADY");
            failures++;
        end

    oneGrant: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !(wrGrant && rdGrant))
        else begin
            $error("Write and read granted in the same cycle");
            failures++;
        end

    csIdle: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !wrReq && !rdReq |-> !cs)
        else begin
            $error("SRAM selected with no request pending");
            failures++;
        end

endmodule

// File: src.f
hdl/axiSramPkg.sv
hdl/sramModel.sv
hdl/sramArbiter.sv
hdl/writeEngine.sv
hdl/readEngine.sv
hdl/axiSramTop.sv
sim/axiSram_assertions.sv
sim/axiSramTb.sv
